/* verilog/vlsu_pkg.sv */
/*
 * Shared sizes and enums for the vector load/store unit.
 * Compile this package before any other design file. Modules import it
 * inside their bodies and use scoped names in their port lists.
 */

package vlsu_pkg;

    //////////////////////////////////////////////////
    // register and memory sizes
    //////////////////////////////////////////////////

    // one vector register
    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;

    // vl and element index, 0 to 8
    localparam int VL_W = 4;

    // requests the memory accepts before it must hand a credit back
    localparam int MEM_CREDITS = 4;
    localparam int CREDIT_W    = 3;

    // in-flight queue pointer, wraps at MEM_CREDITS (power of two)
    localparam int QPTR_W = $clog2(MEM_CREDITS);

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    // log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } elem_width_e;

    typedef enum logic {
        VOP_LOAD  = 1'b0,
        VOP_STORE = 1'b1
    } vlsu_op_e;

    typedef enum logic [1:0] {
        VLSU_IDLE  = 2'd0,
        VLSU_ISSUE = 2'd1,
        VLSU_DRAIN = 2'd2
    } vlsu_state_e;

endpackage

/* verilog/vlsu_elem_if.sv */
/*
 * Issued-element bus from the sequencer to the store and load paths.
 * The sequencer drives every signal, the other two blocks only listen.
 */

`timescale 1ns/1ps

interface vlsu_elem_if;
    import vlsu_pkg::*;

    // command accepted, one cycle
    logic            start;
    // held from start until the next start
    elem_width_e     width;
    logic            is_store;
    // one cycle per element, qualifies the fields below
    logic            issue_valid;
    logic [VL_W-1:0] elem_idx;
    logic [31:0]     address;
    logic            active;

    modport seq_mp (
        output start, width, is_store, issue_valid, elem_idx, address, active
    );

    modport steer_mp (
        input start, width, is_store, issue_valid, elem_idx, address, active
    );

    modport gather_mp (
        input start, width, is_store, issue_valid, elem_idx, address, active
    );

endinterface

/* verilog/vlsu_sequencer.sv */
/*
 * Command latch, FSM, element counter, strided address generation and
 * the memory credit counter. One request per element, at most one per
 * cycle, and only while a credit is available.
 */

`timescale 1ns/1ps

module vlsu_sequencer (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  vlsu_pkg::vlsu_op_e            op_i,
    input  vlsu_pkg::elem_width_e         width_i,
    input  logic [31:0]                   base_address_i,
    input  logic [31:0]                   stride_i,
    input  logic [vlsu_pkg::VL_W-1:0]     vl_i,
    input  logic                          vm_i,
    input  logic [vlsu_pkg::VLENB-1:0]    mask_i,
    input  logic                          mem_rsp_valid_i,
    vlsu_elem_if.seq_mp                   elem,
    output logic                          mem_req_valid_o,
    output logic [31:0]                   mem_address_o,
    output logic                          busy_o,
    output logic                          done_o
);
    import vlsu_pkg::*;

    vlsu_state_e         state;
    vlsu_state_e         next_state;
    elem_width_e         width_r;
    logic                is_store_r;
    logic                vm_r;
    logic [VLENB-1:0]    mask_r;
    logic [31:0]         stride_r;
    logic [31:0]         addr_r;
    logic [VL_W-1:0]     count_r;
    logic [VL_W-1:0]     idx_r;
    logic [VL_W-1:0]     per_reg;
    logic [VL_W-1:0]     start_count;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                accept;
    logic                issue;
    logic                last_issue;
    logic                drained;
    logic                done_r;

    //////////////////////////////////////////////////
    // element count and issue conditions
    //////////////////////////////////////////////////

    assign accept      = start_i && (state == VLSU_IDLE);
    assign per_reg     = VL_W'(VLENB >> width_i);
    assign start_count = (vl_i < per_reg) ? vl_i : per_reg;
    assign issue       = (state == VLSU_ISSUE) && (credit_cnt != '0);
    assign last_issue  = issue && (idx_r == count_r - 1'b1);
    assign drained     = (credit_cnt == CREDIT_W'(MEM_CREDITS));

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            VLSU_IDLE: begin
                // empty command skips straight to drain
                if (accept) begin
                    next_state = (start_count == '0) ? VLSU_DRAIN : VLSU_ISSUE;
                end
            end
            VLSU_ISSUE: begin
                if (last_issue) begin
                    next_state = VLSU_DRAIN;
                end
            end
            VLSU_DRAIN: begin
                if (drained) begin
                    next_state = VLSU_IDLE;
                end
            end
            default: next_state = VLSU_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= VLSU_IDLE;
            done_r <= 1'b0;
        end else begin
            state  <= next_state;
            // done lands in the first idle cycle
            done_r <= (state == VLSU_DRAIN) && drained;
        end
    end

    //////////////////////////////////////////////////
    // command latch, index and address
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            width_r    <= EW8;
            is_store_r <= 1'b0;
            count_r    <= '0;
            idx_r      <= '0;
        end else if (accept) begin
            width_r    <= width_i;
            is_store_r <= (op_i == VOP_STORE);
            count_r    <= start_count;
            idx_r      <= '0;
        end else if (issue) begin
            idx_r <= idx_r + 1'b1;
        end
    end

    // address walks base + idx * stride
    always_ff @(posedge clk) begin
        if (accept) begin
            vm_r     <= vm_i;
            mask_r   <= mask_i;
            stride_r <= stride_i;
            addr_r   <= base_address_i;
        end else if (issue) begin
            addr_r <= addr_r + stride_r;
        end
    end

    // one credit out per request, one back per response
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_cnt <= CREDIT_W'(MEM_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CREDIT_W'(mem_rsp_valid_i) - CREDIT_W'(issue);
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign elem.start       = accept;
    assign elem.width       = width_r;
    assign elem.is_store    = is_store_r;
    assign elem.issue_valid = issue;
    assign elem.elem_idx    = idx_r;
    assign elem.address     = addr_r;
    assign elem.active      = (idx_r < count_r) && (vm_r || mask_r[idx_r[2:0]]);

    assign mem_req_valid_o = issue;
    assign mem_address_o   = addr_r;
    assign busy_o          = (state != VLSU_IDLE);
    assign done_o          = done_r;

    // a response always answers a request still in flight
    a_rsp_has_request: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rsp_valid_i |-> (credit_cnt != CREDIT_W'(MEM_CREDITS)));

    // memory must not return more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
        credit_cnt <= CREDIT_W'(MEM_CREDITS));

endmodule

/* verilog/vlsu_store_steer.sv */
/*
 * Store data path. Latches the source register at command start and, for
 * each issued element, replicates it across the memory word and raises
 * the byte enables that the element address selects.
 */

`timescale 1ns/1ps

module vlsu_store_steer (
    input  logic                       clk,
    input  logic                       reset_n,
    vlsu_elem_if.steer_mp              elem,
    input  logic [vlsu_pkg::VLEN-1:0]  write_data_i,
    output logic [3:0]                 mem_write_enable_o,
    output logic [31:0]                mem_write_data_o
);
    import vlsu_pkg::*;

    logic [VLEN-1:0] data_r;
    logic [7:0]      elem8;
    logic [15:0]     elem16;
    logic [31:0]     elem32;
    logic [3:0]      lane_mask;
    logic            write_ok;

    always_ff @(posedge clk) begin
        if (elem.start) begin
            data_r <= write_data_i;
        end
    end

    // element pick, index range depends on width
    assign elem8  = data_r[8*elem.elem_idx[2:0] +: 8];
    assign elem16 = data_r[16*elem.elem_idx[1:0] +: 16];
    assign elem32 = data_r[32*elem.elem_idx[0] +: 32];

    //////////////////////////////////////////////////
    // lane steering
    //////////////////////////////////////////////////

    always_comb begin
        case (elem.width)
            EW8: begin
                mem_write_data_o = {4{elem8}};
                lane_mask        = 4'b0001 << elem.address[1:0];
            end
            EW16: begin
                mem_write_data_o = {2{elem16}};
                lane_mask        = elem.address[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mem_write_data_o = elem32;
                lane_mask        = 4'b1111;
            end
        endcase
    end

    // masked-off store elements still go out, with no lanes written
    assign write_ok           = elem.issue_valid && elem.is_store && elem.active;
    assign mem_write_enable_o = write_ok ? lane_mask : 4'b0000;

    // lane steering only covers naturally aligned elements
    a_store_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (elem.issue_valid && elem.is_store && elem.width != EW8) |->
            (!elem.address[0] && (elem.width == EW16 || !elem.address[1])));

endmodule

/* verilog/vlsu_load_gather.sv */
/*
 * Load data path. Every issued load element is queued with its index,
 * byte offset and active flag. Responses come back in order, so each one
 * pops the head and drops the extracted element into the result register.
 */

`timescale 1ns/1ps

module vlsu_load_gather (
    input  logic                       clk,
    input  logic                       reset_n,
    vlsu_elem_if.gather_mp             elem,
    input  logic                       mem_rsp_valid_i,
    input  logic [31:0]                mem_read_data_i,
    output logic [vlsu_pkg::VLEN-1:0]  read_data_o
);
    import vlsu_pkg::*;

    logic [VL_W-1:0]     q_idx [MEM_CREDITS];
    logic [1:0]          q_off [MEM_CREDITS];
    logic                q_act [MEM_CREDITS];
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [CREDIT_W-1:0] q_count;
    logic                push;
    logic                pop;
    logic [VL_W-1:0]     h_idx;
    logic [1:0]          h_off;
    logic                h_act;
    logic [7:0]          rsp8;
    logic [15:0]         rsp16;
    logic [31:0]         rsp32;

    // store responses only return credits
    assign push = elem.issue_valid && !elem.is_store;
    assign pop  = mem_rsp_valid_i && !elem.is_store;

    //////////////////////////////////////////////////
    // in-flight queue
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            q_idx[wr_ptr] <= elem.elem_idx;
            q_off[wr_ptr] <= elem.address[1:0];
            q_act[wr_ptr] <= elem.active;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_count <= q_count + CREDIT_W'(push) - CREDIT_W'(pop);
        end
    end

    assign h_idx = q_idx[rd_ptr];
    assign h_off = q_off[rd_ptr];
    assign h_act = q_act[rd_ptr];

    //////////////////////////////////////////////////
    // extraction and result update
    //////////////////////////////////////////////////

    // inactive elements land as zero
    assign rsp8  = h_act ? mem_read_data_i[8*h_off +: 8] : 8'h00;
    assign rsp16 = h_act ? mem_read_data_i[16*h_off[1] +: 16] : 16'h0000;
    assign rsp32 = h_act ? mem_read_data_i : 32'h0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_data_o <= '0;
        end else if (elem.start) begin
            read_data_o <= '0;
        end else if (pop) begin
            case (elem.width)
                EW8:     read_data_o[8*h_idx[2:0] +: 8]   <= rsp8;
                EW16:    read_data_o[16*h_idx[1:0] +: 16] <= rsp16;
                default: read_data_o[32*h_idx[0] +: 32]   <= rsp32;
            endcase
        end
    end

    // in-order memory never answers a load it was not asked for
    a_rsp_has_entry: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_rsp_valid_i && !elem.is_store) |-> (q_count != '0));

endmodule

/* verilog/vlsu_top.sv */
/*
 * Top level of the vector load/store unit. Connects the sequencer, the
 * store steer and the load gather through the element bus and exposes
 * the command, register and credit-based memory ports.
 */

`timescale 1ns/1ps

module vlsu_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  vlsu_pkg::vlsu_op_e            op_i,
    input  vlsu_pkg::elem_width_e         width_i,
    input  logic [31:0]                   base_address_i,
    input  logic [31:0]                   stride_i,
    input  logic [vlsu_pkg::VL_W-1:0]     vl_i,
    input  logic                          vm_i,
    input  logic [vlsu_pkg::VLENB-1:0]    mask_i,
    input  logic [vlsu_pkg::VLEN-1:0]     write_data_i,
    output logic                          busy_o,
    output logic                          done_o,
    output logic [vlsu_pkg::VLEN-1:0]     read_data_o,
    output logic                          mem_req_valid_o,
    output logic [31:0]                   mem_address_o,
    output logic [3:0]                    mem_write_enable_o,
    output logic [31:0]                   mem_write_data_o,
    input  logic                          mem_rsp_valid_i,
    input  logic [31:0]                   mem_read_data_i
);

    vlsu_elem_if elem_bus ();

    vlsu_sequencer u_sequencer (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start_i),
        .op_i            (op_i),
        .width_i         (width_i),
        .base_address_i  (base_address_i),
        .stride_i        (stride_i),
        .vl_i            (vl_i),
        .vm_i            (vm_i),
        .mask_i          (mask_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .elem            (elem_bus.seq_mp),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_address_o   (mem_address_o),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    vlsu_store_steer u_store_steer (
        .clk                (clk),
        .reset_n            (reset_n),
        .elem               (elem_bus.steer_mp),
        .write_data_i       (write_data_i),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    vlsu_load_gather u_load_gather (
        .clk             (clk),
        .reset_n         (reset_n),
        .elem            (elem_bus.gather_mp),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_read_data_i (mem_read_data_i),
        .read_data_o     (read_data_o)
    );

endmodule

/* dv/vlsu_mem_model.sv */
/*
 * Byte-addressed memory model for the vector load/store testbench.
 * Stores write at request time under the byte enables. Every request,
 * load or store, is answered in order after a random delay of 1 to 4
 * cycles, and each response hands one credit back.
 */

`timescale 1ns/1ps

module vlsu_mem_model (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        slow_i,
    input  logic        req_valid_i,
    input  logic [31:0] address_i,
    input  logic [3:0]  write_enable_i,
    input  logic [31:0] write_data_i,
    output logic        rsp_valid_o,
    output logic [31:0] read_data_o,
    output logic [3:0]  outstanding_o
);

    logic [7:0]  mem [256];
    logic [31:0] data_q [$];
    int          due_q [$];
    integer      seed = 60;
    int          cycle;
    int          last_due;
    int          delay;
    logic [7:0]  word_addr;
    logic [31:0] rdata;

    // fill depends on every address bit, 37 is odd so no two bytes repeat
    initial begin
        rsp_valid_o   = 1'b0;
        read_data_o   = '0;
        outstanding_o = '0;
        for (int a = 0; a < 256; a++) begin
            mem[8'(a)] = 8'(a * 37 + 'h5a);
        end
    end

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rsp_valid_o   <= 1'b0;
            read_data_o   <= '0;
            outstanding_o <= '0;
            cycle    = 0;
            last_due = 0;
            due_q.delete();
            data_q.delete();
        end else begin
            cycle = cycle + 1;
            if (req_valid_i) begin
                word_addr = {address_i[7:2], 2'b00};
                for (int b = 0; b < 4; b++) begin
                    if (write_enable_i[2'(b)]) begin
                        mem[word_addr + 8'(b)] = write_data_i[8*b +: 8];
                    end
                end
                delay = slow_i ? 4 : 1 + int'($unsigned($random(seed)) % 32'd4);
                // in order, so never due before the previous response
                last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1;
                due_q.push_back(last_due);
                data_q.push_back({mem[word_addr + 8'd3], mem[word_addr + 8'd2],
                                  mem[word_addr + 8'd1], mem[word_addr]});
            end
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                rdata = data_q.pop_front();
                rsp_valid_o <= 1'b1;
                read_data_o <= rdata;
            end else begin
                rsp_valid_o <= 1'b0;
            end
            outstanding_o <= outstanding_o + 4'(req_valid_i) - 4'(rsp_valid_o);
        end
    end

endmodule

/* dv/tb_vlsu.sv */
/*
 * Testbench for the vector load/store unit. Drives commands into
 * vlsu_top, answers its requests through the delayed memory model and
 * checks register results and memory against a shadow byte array.
 */

`timescale 1ns/1ps

module tb_vlsu;
    import vlsu_pkg::*;

    // tests need about 300 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic             clk;
    logic             reset_n = 1'b0;
    logic             start_i;
    vlsu_op_e         op_i;
    elem_width_e      width_i;
    logic [31:0]      base_address_i;
    logic [31:0]      stride_i;
    logic [VL_W-1:0]  vl_i;
    logic             vm_i;
    logic [VLENB-1:0] mask_i;
    logic [VLEN-1:0]  write_data_i;
    logic             busy_o;
    logic             done_o;
    logic [VLEN-1:0]  read_data_o;
    logic             mem_req_valid_o;
    logic [31:0]      mem_address_o;
    logic [3:0]       mem_write_enable_o;
    logic [31:0]      mem_write_data_o;
    logic             mem_rsp_valid_i;
    logic [31:0]      mem_read_data_i;
    logic             mem_slow;
    logic [3:0]       outstanding;
    logic [7:0]       shadow [256];
    int               errors = 0;
    int               checks = 0;
    int               cycle_count = 0;
    int               req_count = 0;
    int               req_before;
    int               cycles;

    vlsu_top dut (.*);

    vlsu_mem_model mem_model (
        .clk            (clk),
        .reset_n        (reset_n),
        .slow_i         (mem_slow),
        .req_valid_i    (mem_req_valid_o),
        .address_i      (mem_address_o),
        .write_enable_i (mem_write_enable_o),
        .write_data_i   (mem_write_data_o),
        .rsp_valid_o    (mem_rsp_valid_i),
        .read_data_o    (mem_read_data_i),
        .outstanding_o  (outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (mem_req_valid_o) begin
            req_count <= req_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // protocol checks
    //////////////////////////////////////////////////

    a_credit_limit: assert property (@(posedge clk) disable iff (!reset_n)
        outstanding <= 4'(MEM_CREDITS))
        else begin
            errors = errors + 1;
            $display("more requests outstanding than the memory has credits for");
        end

    a_done_after_rsp: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> (outstanding == 4'd0))
        else begin
            errors = errors + 1;
            $display("done_o came while responses were still outstanding");
        end

    a_done_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> !busy_o)
        else begin
            errors = errors + 1;
            $display("busy_o was still high while done_o was high");
        end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        checks = checks + 1;
        assert (actual === expected) else begin
            errors = errors + 1;
            $display("ERROR %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    // walks the elements by the command rules, loads fill res, stores update shadow
    task automatic reference_command(input logic is_store, input elem_width_e width,
                                     input logic [31:0] base, input logic [31:0] stride,
                                     input logic [VL_W-1:0] vl, input logic vm,
                                     input logic [VLENB-1:0] mask,
                                     input logic [VLEN-1:0] wdata,
                                     output logic [VLEN-1:0] res);
        logic [7:0] a8;
        int         nbytes;
        int         count;
        res    = '0;
        nbytes = 1 << width;
        count  = (int'(vl) < VLENB / nbytes) ? int'(vl) : VLENB / nbytes;
        for (int i = 0; i < count; i++) begin
            if (vm || mask[3'(i)]) begin
                for (int b = 0; b < nbytes; b++) begin
                    a8 = 8'(base + 32'(i) * stride + 32'(b));
                    if (is_store) begin
                        shadow[a8] = wdata[8*(i*nbytes+b) +: 8];
                    end else begin
                        res[8*(i*nbytes+b) +: 8] = shadow[a8];
                    end
                end
            end
        end
    endtask

    // one command, start held for one cycle, counts cycles until done_o
    task automatic run_command(input vlsu_op_e op, input elem_width_e width,
                               input logic [31:0] base, input logic [31:0] stride,
                               input logic [VL_W-1:0] vl, input logic vm,
                               input logic [VLENB-1:0] mask, input logic [VLEN-1:0] wdata);
        @(posedge clk);
        #2;
        op_i           = op;
        width_i        = width;
        base_address_i = base;
        stride_i       = stride;
        vl_i           = vl;
        vm_i           = vm;
        mask_i         = mask;
        write_data_i   = wdata;
        start_i        = 1'b1;
        req_before     = req_count;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles == 1) begin
                checks = checks + 1;
                assert (busy_o) else begin
                    errors = errors + 1;
                    $display("busy_o did not rise the cycle after start_i");
                end
            end
        end while (!done_o);
    endtask

    task automatic load_and_check(input elem_width_e width, input logic [31:0] base,
                                  input logic [31:0] stride, input logic [VL_W-1:0] vl,
                                  input logic vm, input logic [VLENB-1:0] mask);
        logic [VLEN-1:0] expected;
        run_command(VOP_LOAD, width, base, stride, vl, vm, mask, '0);
        reference_command(1'b0, width, base, stride, vl, vm, mask, '0, expected);
        expect_equal("read_data_o", expected, read_data_o);
    endtask

    task automatic store_and_check(input elem_width_e width, input logic [31:0] base,
                                   input logic [31:0] stride, input logic [VL_W-1:0] vl,
                                   input logic vm, input logic [VLENB-1:0] mask,
                                   input logic [VLEN-1:0] wdata);
        logic [VLEN-1:0] unused_res;
        run_command(VOP_STORE, width, base, stride, vl, vm, mask, wdata);
        reference_command(1'b1, width, base, stride, vl, vm, mask, wdata, unused_res);
        for (int a = 0; a < 256; a++) begin
            expect_equal($sformatf("mem[0x%02h]", a), 64'(shadow[8'(a)]),
                         64'(mem_model.mem[8'(a)]));
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        start_i        = 1'b0;
        op_i           = VOP_LOAD;
        width_i        = EW8;
        base_address_i = '0;
        stride_i       = '0;
        vl_i           = '0;
        vm_i           = 1'b0;
        mask_i         = '0;
        write_data_i   = '0;
        mem_slow       = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;
        for (int a = 0; a < 256; a++) begin
            shadow[8'(a)] = mem_model.mem[8'(a)];
        end

        // unit-stride word load, then strided byte store under a mask
        load_and_check(EW32, 32'h40, 32'd4, 4'd2, 1'b1, 8'h00);
        store_and_check(EW8, 32'h80, 32'd3, 4'd8, 1'b0, 8'b1011_0101,
                        64'hf7e6_d5c4_b3a2_9180);

        // halfwords at offset 2, element 2 masked off
        load_and_check(EW16, 32'h22, 32'd6, 4'd4, 1'b0, 8'b0000_1011);
        store_and_check(EW16, 32'ha2, 32'd4, 4'd3, 1'b0, 8'b0000_0101,
                        64'h1357_9bdf_2468_ace0);

        // long delays run the credits dry
        mem_slow = 1'b1;
        store_and_check(EW32, 32'hc0, 32'd8, 4'd2, 1'b1, 8'h00, 64'hcafe_f00d_0bad_beef);
        load_and_check(EW8, 32'h80, 32'd1, 4'd6, 1'b1, 8'h00);
        mem_slow = 1'b0;

        // vl clipped to the element count, then an empty command
        load_and_check(EW32, 32'ha0, 32'd4, 4'd5, 1'b1, 8'h00);
        expect_equal("req_count", 64'd2, 64'(req_count - req_before));
        store_and_check(EW8, 32'h10, 32'd1, 4'd0, 1'b1, 8'hff, '1);
        expect_equal("req_count", 64'd0, 64'(req_count - req_before));
        expect_equal("done_cycles", 64'd2, 64'(cycles));

        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, done_o never arrived", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

/* vlsu.f */
verilog/vlsu_pkg.sv
verilog/vlsu_elem_if.sv
verilog/vlsu_sequencer.sv
verilog/vlsu_store_steer.sv
verilog/vlsu_load_gather.sv
verilog/vlsu_top.sv
dv/vlsu_mem_model.sv
dv/tb_vlsu.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vlsu -f vlsu.f \
    || { echo "build error"; exit 1; }

out=$(./obj_dir/Vtb_vlsu)
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
